//--- sim.f
+incdir+include
logic/cpu_pkg.sv
logic/cpu_decoder.sv
logic/cpu_reg_file.sv
logic/cpu_alu.sv
logic/cpu_csrs.sv
logic/cpu_control.sv
logic/cpu.sv
dv/cpu_tb_mem.sv
dv/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu

export_include_dirs:
  - include

sources:
  - files:
      - logic/cpu_pkg.sv
      - logic/cpu_decoder.sv
      - logic/cpu_reg_file.sv
      - logic/cpu_alu.sv
      - logic/cpu_csrs.sv
      - logic/cpu_control.sv
      - logic/cpu.sv
  - target: simulation
    files:
      - dv/cpu_tb_mem.sv
      - dv/cpu_tb.sv

//--- dv/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpu_tb import cpu_pkg::*;;
	localparam logic [31:0] res = 32'h4000_2000;
	localparam logic [31:0] dat = 32'h4000_3000;
	localparam logic [31:0] done_addr = 32'h4000_2ffc;
	localparam logic [31:0] start = `CPU_EXEC_START_ADDR;
	localparam int cycle_limit = 4000;

	logic        clk;
	logic        rst;
	logic [31:0] ma_addr;
	logic [31:0] ma_data_out;
	logic [31:0] ma_data_in;
	logic        ma_rd_req;
	logic        ma_wr_req;
	logic [3:0]  ma_data_mask;
	logic        ma_done;
	logic        ma_timeout;

	logic [31:0] exp_addr [0:63];
	logic [31:0] exp_data [0:63];
	logic [3:0]  exp_mask [0:63];
	int          n_expected;
	int          store_idx;
	int          cycles;
	logic        fetch_seen;
	logic        store_seen;
	logic        store_hit;

	cpu i_dut (
		.clk(clk),
		.rst(rst),
		.ma_addr(ma_addr),
		.ma_data_out(ma_data_out),
		.ma_data_in(ma_data_in),
		.ma_rd_req(ma_rd_req),
		.ma_wr_req(ma_wr_req),
		.ma_data_mask(ma_data_mask),
		.ma_done(ma_done),
		.ma_timeout(ma_timeout)
	);

	cpu_tb_mem i_mem (
		.clk(clk),
		.rst(rst),
		.ma_addr(ma_addr),
		.ma_data_out(ma_data_out),
		.ma_data_in(ma_data_in),
		.ma_rd_req(ma_rd_req),
		.ma_wr_req(ma_wr_req),
		.ma_data_mask(ma_data_mask),
		.ma_done(ma_done),
		.ma_timeout(ma_timeout)
	);

	task automatic expect_store(input logic [31:0] a, input logic [31:0] d,
		input logic [3:0] m);
		exp_addr[n_expected] = a;
		exp_data[n_expected] = d;
		exp_mask[n_expected] = m;
		n_expected++;
	endtask

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, want);
		$display("Verification failed");
		$fatal(1, "simulation stopped on error");
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		n_expected = 0;
		// alu and upper immediates
		expect_store(res + 32'h00, 32'h1234_5000, 4'hf);
		expect_store(res + 32'h04, start + 32'h1018, 4'hf);
		expect_store(res + 32'h08, 32'h0000_0002, 4'hf);
		expect_store(res + 32'h0c, 32'h0000_000c, 4'hf);
		expect_store(res + 32'h10, 32'h0000_0001, 4'hf);
		expect_store(res + 32'h14, 32'h0000_0000, 4'hf);
		expect_store(res + 32'h18, 32'hffff_fffd, 4'hf);
		expect_store(res + 32'h1c, 32'h01ff_ffff, 4'hf);
		expect_store(res + 32'h20, 32'h0000_0070, 4'hf);
		expect_store(res + 32'h24, 32'hffff_ff0b, 4'hf);
		expect_store(res + 32'h28, 32'h1234_5007, 4'hf);
		expect_store(res + 32'h2c, 32'h0000_007b, 4'hf);
		expect_store(res + 32'h30, 32'h0000_0001, 4'hf);
		// loads and stores of each width
		expect_store(dat, 32'h8182_83f4, 4'hf);
		expect_store(res + 32'h34, 32'hffff_fff4, 4'hf);
		expect_store(res + 32'h38, 32'h0000_0083, 4'hf);
		expect_store(res + 32'h3c, 32'hffff_8182, 4'hf);
		expect_store(res + 32'h40, 32'h0000_83f4, 4'hf);
		expect_store(dat + 32'h4, 32'h0000_0000, 4'hf);
		expect_store(dat + 32'h4, 32'h0000_0007, 4'h1);
		expect_store(dat + 32'h6, 32'hffff_fffb, 4'h3);
		expect_store(res + 32'h44, 32'hfffb_0007, 4'hf);
		// branch marker and link values
		expect_store(res + 32'h48, 32'h0000_0031, 4'hf);
		expect_store(res + 32'h4c, start + 32'h12c, 4'hf);
		expect_store(res + 32'h50, start + 32'h144, 4'hf);
		// handler reports of cause, value and epc
		expect_store(res + 32'h54, exc_load_misaligned, 4'hf);
		expect_store(res + 32'h58, dat + 32'h1, 4'hf);
		expect_store(res + 32'h5c, start + 32'h154, 4'hf);
		expect_store(res + 32'h60, exc_super_ecall, 4'hf);
		expect_store(res + 32'h64, 32'h0, 4'hf);
		expect_store(res + 32'h68, start + 32'h158, 4'hf);
		expect_store(res + 32'h6c, exc_illegal, 4'hf);
		expect_store(res + 32'h70, 32'h0, 4'hf);
		expect_store(res + 32'h74, start + 32'h15c, 4'hf);
		expect_store(res + 32'h78, exc_load_fault, 4'hf);
		expect_store(res + 32'h7c, 32'h5000_0000, 4'hf);
		expect_store(res + 32'h80, start + 32'h160, 4'hf);
		// sscratch after set and clear
		expect_store(res + 32'h84, 32'h0000_00ff, 4'hf);
		expect_store(res + 32'h88, 32'h0000_00cf, 4'hf);
		repeat (2) @(negedge clk);
		rst = 1'b0;
	end

	assign store_seen = ma_wr_req && ma_done;

	always @(posedge clk or posedge rst) begin
		if (rst) begin
			fetch_seen <= 1'b0;
			store_hit <= 1'b0;
		end else begin
			if (ma_rd_req)
				fetch_seen <= 1'b1;
			store_hit <= store_seen && ma_addr != done_addr;
		end
	end

	// next list entry, taken up between two rising edges
	always @(negedge clk or posedge rst) begin
		if (rst)
			store_idx <= 0;
		else if (store_hit)
			store_idx <= store_idx + 1;
	end

	always @(posedge clk) begin
		if (!rst && store_seen && ma_addr == done_addr) begin
			if (store_idx == n_expected) begin
				$display("Verification passed");
				$finish;
			end else begin
				stop_run("program finished before all expected stores were seen");
			end
		end
	end

	always @(posedge clk) begin
		if (rst)
			cycles <= 0;
		else
			cycles <= cycles + 1;
		if (cycles == cycle_limit)
			stop_run("cycle limit reached without the program finishing");
	end

	assert property (@(posedge clk) rst |-> !ma_rd_req && !ma_wr_req)
		else stop_run("memory request active during reset");

	assert property (@(posedge clk) disable iff (rst) !(ma_rd_req && ma_wr_req))
		else stop_run("read and write requests high together");

	assert property (@(posedge clk) disable iff (rst) ma_rd_req && !fetch_seen |->
		ma_addr == start)
		else mismatch("ma_addr", ma_addr, start);

	assert property (@(posedge clk) disable iff (rst)
		store_seen && ma_addr != done_addr |-> store_idx < n_expected)
		else stop_run("more stores than expected");

	assert property (@(posedge clk) disable iff (rst)
		store_seen && ma_addr != done_addr |-> ma_addr == exp_addr[store_idx])
		else mismatch("ma_addr", ma_addr, exp_addr[store_idx]);

	assert property (@(posedge clk) disable iff (rst)
		store_seen && ma_addr != done_addr |-> ma_data_out == exp_data[store_idx])
		else mismatch("ma_data_out", ma_data_out, exp_data[store_idx]);

	assert property (@(posedge clk) disable iff (rst)
		store_seen && ma_addr != done_addr |-> ma_data_mask == exp_mask[store_idx])
		else mismatch("ma_data_mask", {28'b0, ma_data_mask}, {28'b0, exp_mask[store_idx]});

endmodule

`default_nettype wire

//--- dv/cpu_tb_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpu_tb_mem import cpu_pkg::*; (
	input  wire logic        clk,
	input  wire logic        rst,
	input  wire logic [31:0] ma_addr,
	input  wire logic [31:0] ma_data_out,
	output logic [31:0]      ma_data_in,
	input  wire logic        ma_rd_req,
	input  wire logic        ma_wr_req,
	input  wire logic [3:0]  ma_data_mask,
	output logic             ma_done,
	output logic             ma_timeout
);
	localparam logic [31:0] base = `CPU_EXEC_START_ADDR;
	localparam int size = 16384;

	logic [7:0]  bytes [0:size-1];
	logic [31:0] put_addr;
	logic        busy;
	logic [1:0]  delay;
	integer      seed;
	integer      rnd;

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
	endfunction

	task automatic emit(input logic [31:0] word);
		logic [31:0] off;
		off = put_addr - base;
		bytes[off] = word[7:0];
		bytes[off+1] = word[15:8];
		bytes[off+2] = word[23:16];
		bytes[off+3] = word[31:24];
		put_addr = put_addr + 32'd4;
	endtask

	// store through the result pointer x10, then bump it
	task automatic report_reg(input logic [4:0] r);
		emit(s_type(12'd0, r, 5'd10, lw_word));
		emit(i_type(12'd4, 5'd10, 3'd0, 5'd10, 7'h13));
	endtask

	task automatic read_csr(input logic [11:0] csr, input logic [4:0] rd);
		emit(i_type(csr, 5'd0, csr_rs, rd, 7'h73));
	endtask

	task automatic load_program;
		put_addr = base;
		emit(u_type(20'h40002, 5'd10, 7'h37));
		emit(u_type(20'h40003, 5'd11, 7'h37));
		emit(u_type(20'h50000, 5'd12, 7'h37));
		emit(u_type(20'h12345, 5'd1, 7'h37));
		report_reg(5'd1);
		emit(u_type(20'h00001, 5'd2, 7'h17));
		report_reg(5'd2);
		emit(i_type(12'hffb, 5'd0, 3'd0, 5'd3, 7'h13));
		emit(i_type(12'd7, 5'd0, 3'd0, 5'd4, 7'h13));
		emit(r_type(7'h00, 5'd4, 5'd3, 3'd0, 5'd5));
		report_reg(5'd5);
		emit(r_type(7'h20, 5'd3, 5'd4, 3'd0, 5'd5));
		report_reg(5'd5);
		emit(r_type(7'h00, 5'd4, 5'd3, 3'd2, 5'd5));
		report_reg(5'd5);
		emit(r_type(7'h00, 5'd4, 5'd3, 3'd3, 5'd5));
		report_reg(5'd5);
		emit(i_type(12'h401, 5'd3, 3'd5, 5'd5, 7'h13));
		report_reg(5'd5);
		emit(r_type(7'h00, 5'd4, 5'd3, 3'd5, 5'd5));
		report_reg(5'd5);
		emit(i_type(12'd4, 5'd4, 3'd1, 5'd5, 7'h13));
		report_reg(5'd5);
		emit(i_type(12'h0f0, 5'd3, 3'd4, 5'd5, 7'h13));
		report_reg(5'd5);
		emit(r_type(7'h00, 5'd4, 5'd1, 3'd6, 5'd5));
		report_reg(5'd5);
		emit(i_type(12'h07f, 5'd3, 3'd7, 5'd5, 7'h13));
		report_reg(5'd5);
		emit(i_type(12'hffc, 5'd3, 3'd2, 5'd5, 7'h13));
		report_reg(5'd5);
		// pattern word 8182_83f4 in the data area
		emit(u_type(20'h81828, 5'd6, 7'h37));
		emit(i_type(12'h3f4, 5'd6, 3'd0, 5'd6, 7'h13));
		emit(s_type(12'd0, 5'd6, 5'd11, lw_word));
		emit(i_type(12'd0, 5'd11, lw_byte, 5'd5, 7'h03));
		report_reg(5'd5);
		emit(i_type(12'd1, 5'd11, lw_byte_u, 5'd5, 7'h03));
		report_reg(5'd5);
		emit(i_type(12'd2, 5'd11, lw_half, 5'd5, 7'h03));
		report_reg(5'd5);
		emit(i_type(12'd0, 5'd11, lw_half_u, 5'd5, 7'h03));
		report_reg(5'd5);
		emit(s_type(12'd4, 5'd0, 5'd11, lw_word));
		emit(s_type(12'd4, 5'd4, 5'd11, lw_byte));
		emit(s_type(12'd6, 5'd3, 5'd11, lw_half));
		emit(i_type(12'd4, 5'd11, lw_word, 5'd5, 7'h03));
		report_reg(5'd5);
		// branch paths, each wrong turn adds its own bits to x7
		emit(i_type(12'h011, 5'd0, 3'd0, 5'd7, 7'h13));
		emit(b_type(13'd8, 5'd4, 5'd3, 3'd0));
		emit(i_type(12'h020, 5'd7, 3'd0, 5'd7, 7'h13));
		emit(b_type(13'd8, 5'd4, 5'd3, 3'd4));
		emit(i_type(12'h100, 5'd7, 3'd0, 5'd7, 7'h13));
		emit(b_type(13'd8, 5'd4, 5'd3, 3'd7));
		emit(i_type(12'h200, 5'd7, 3'd0, 5'd7, 7'h13));
		report_reg(5'd7);
		emit(j_type(21'd12, 5'd8));
		emit(i_type(12'h044, 5'd0, 3'd0, 5'd8, 7'h13));
		emit(i_type(12'h055, 5'd0, 3'd0, 5'd8, 7'h13));
		report_reg(5'd8);
		emit(u_type(20'h00000, 5'd9, 7'h17));
		emit(i_type(12'd16, 5'd9, 3'd0, 5'd13, 7'h67));
		emit(i_type(12'h066, 5'd0, 3'd0, 5'd13, 7'h13));
		emit(i_type(12'h077, 5'd0, 3'd0, 5'd13, 7'h13));
		report_reg(5'd13);
		// misaligned load, ecall, write to cycle, load from the timeout window
		emit(i_type(12'd1, 5'd11, lw_word, 5'd5, 7'h03));
		emit(32'h0000_0073);
		emit(i_type(12'hc00, 5'd4, csr_rw, 5'd5, 7'h73));
		emit(i_type(12'd0, 5'd12, lw_word, 5'd5, 7'h03));
		emit(i_type(12'h0f0, 5'd0, 3'd0, 5'd14, 7'h13));
		emit(i_type(12'h140, 5'd14, csr_rw, 5'd0, 7'h73));
		emit(i_type(12'h00f, 5'd0, 3'd0, 5'd15, 7'h13));
		emit(i_type(12'h140, 5'd15, csr_rs, 5'd0, 7'h73));
		emit(i_type(12'h030, 5'd0, 3'd0, 5'd15, 7'h13));
		emit(i_type(12'h140, 5'd15, csr_rc, 5'd5, 7'h73));
		report_reg(5'd5);
		read_csr(12'h140, 5'd5);
		report_reg(5'd5);
		emit(32'h0ff0_000f);
		emit(i_type(12'h05a, 5'd0, 3'd0, 5'd16, 7'h13));
		emit(s_type(12'hffc, 5'd16, 5'd11, lw_word));
		emit(j_type(21'd0, 5'd0));

		// trap handler reports scause, stval, sepc and skips the faulting insn
		put_addr = `CPU_TRAP_VECTOR_RST;
		read_csr(12'h142, 5'd28);
		report_reg(5'd28);
		read_csr(12'h143, 5'd29);
		report_reg(5'd29);
		read_csr(12'h141, 5'd30);
		report_reg(5'd30);
		emit(i_type(12'd4, 5'd30, 3'd0, 5'd30, 7'h13));
		emit(i_type(12'h141, 5'd30, csr_rw, 5'd0, 7'h73));
		emit(32'h1020_0073);
	endtask

	task automatic answer;
		logic [31:0] off;
		off = ma_addr - base;
		if (ma_addr < base || off > size - 4) begin
			ma_timeout <= 1'b1;
		end else begin
			if (ma_wr_req) begin
				for (int i = 0; i < 4; i++)
					if (ma_data_mask[i])
						bytes[off+i] = ma_data_out[8*i +: 8];
			end else begin
				ma_data_in <= {bytes[off+3], bytes[off+2], bytes[off+1], bytes[off]};
			end
			ma_done <= 1'b1;
		end
	endtask

	initial begin
		logic [31:0] a;
		seed = 32'hfa0e_b140;
		ma_data_in = 32'b0;
		ma_done = 1'b0;
		ma_timeout = 1'b0;
		busy = 1'b0;
		delay = 2'd0;
		for (int i = 0; i < size; i++) begin
			a = base + i;
			bytes[i] = a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24];
		end
		load_program();
	end

	// answers 1 to 4 cycles after the request shows up
	always @(negedge clk) begin
		if (rst) begin
			ma_done <= 1'b0;
			ma_timeout <= 1'b0;
			busy <= 1'b0;
		end else begin
			ma_done <= 1'b0;
			ma_timeout <= 1'b0;
			if (busy) begin
				if (delay == 2'd0) begin
					busy <= 1'b0;
					answer();
				end else begin
					delay <= delay - 2'd1;
				end
			end else if (ma_rd_req || ma_wr_req) begin
				rnd = $random(seed);
				busy <= 1'b1;
				delay <= rnd[1:0];
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu import cpu_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	output logic [31:0] ma_addr,
	output logic [31:0] ma_data_out,
	input  logic [31:0] ma_data_in,
	output logic        ma_rd_req,
	output logic        ma_wr_req,
	output logic [3:0]  ma_data_mask,
	input  logic        ma_done,
	input  logic        ma_timeout
);
	logic        ir_load;
	opcode_e     opcode;
	logic [2:0]  funct3;
	logic        funct7_bit5;
	logic [4:0]  rd;
	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [31:0] imm;
	logic [11:0] csr_addr;
	logic [31:0] rs1_data;
	logic [31:0] rs2_data;
	logic        rf_wr;
	logic [31:0] rf_wr_data;
	logic        alu_use_imm;
	logic [31:0] alu_result;
	logic        branch_taken;
	logic        csr_wr;
	logic [31:0] csr_wr_data;
	logic [31:0] csr_rd_data;
	logic        csr_addr_allowed;
	logic        trap_enter;
	exc_cause_e  trap_cause;
	logic [31:0] trap_pc;
	logic [31:0] trap_value;
	logic        trap_leave;
	logic [31:0] trap_vector;
	logic [31:0] return_addr;
	logic        supervisor_mode;
	ctrl_state_e state;

	cpu_control i_control (
		.clk(clk),
		.rst(rst),
		.ma_addr(ma_addr),
		.ma_data_out(ma_data_out),
		.ma_data_in(ma_data_in),
		.ma_rd_req(ma_rd_req),
		.ma_wr_req(ma_wr_req),
		.ma_data_mask(ma_data_mask),
		.ma_done(ma_done),
		.ma_timeout(ma_timeout),
		.ir_load(ir_load),
		.opcode(opcode),
		.funct3(funct3),
		.rd(rd),
		.rs1(rs1),
		.imm(imm),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.alu_result(alu_result),
		.branch_taken(branch_taken),
		.alu_use_imm(alu_use_imm),
		.rf_wr(rf_wr),
		.rf_wr_data(rf_wr_data),
		.csr_wr(csr_wr),
		.csr_wr_data(csr_wr_data),
		.csr_rd_data(csr_rd_data),
		.csr_addr_allowed(csr_addr_allowed),
		.trap_enter(trap_enter),
		.trap_cause(trap_cause),
		.trap_pc(trap_pc),
		.trap_value(trap_value),
		.trap_leave(trap_leave),
		.trap_vector(trap_vector),
		.return_addr(return_addr),
		.supervisor_mode(supervisor_mode),
		.state(state)
	);

	cpu_decoder i_decoder (
		.clk(clk),
		.rst(rst),
		.load(ir_load),
		.instr(ma_data_in),
		.opcode(opcode),
		.funct3(funct3),
		.funct7_bit5(funct7_bit5),
		.rd(rd),
		.rs1(rs1),
		.rs2(rs2),
		.imm(imm),
		.csr_addr(csr_addr)
	);

	cpu_reg_file i_reg_file (
		.clk(clk),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.wr(rf_wr),
		.wr_data(rf_wr_data),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data)
	);

	cpu_alu i_alu (
		.opcode(opcode),
		.funct3(funct3),
		.funct7_bit5(funct7_bit5),
		.use_imm(alu_use_imm),
		.a(rs1_data),
		.b(rs2_data),
		.imm(imm),
		.result(alu_result),
		.branch_taken(branch_taken)
	);

	cpu_csrs i_csrs (
		.clk(clk),
		.rst(rst),
		.addr(csr_addr),
		.addr_allowed(csr_addr_allowed),
		.wr(csr_wr),
		.wr_data(csr_wr_data),
		.rd_data(csr_rd_data),
		.state(state),
		.trap_enter(trap_enter),
		.cause(trap_cause),
		.trap_pc(trap_pc),
		.trap_value(trap_value),
		.trap_leave(trap_leave),
		.trap_vector(trap_vector),
		.return_addr(return_addr),
		.supervisor_mode(supervisor_mode)
	);

endmodule

`default_nettype wire

//--- logic/cpu_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpu_control import cpu_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	output logic [31:0] ma_addr,
	output logic [31:0] ma_data_out,
	input  logic [31:0] ma_data_in,
	output logic        ma_rd_req,
	output logic        ma_wr_req,
	output logic [3:0]  ma_data_mask,
	input  logic        ma_done,
	input  logic        ma_timeout,
	output logic        ir_load,
	input  opcode_e     opcode,
	input  logic [2:0]  funct3,
	input  logic [4:0]  rd,
	input  logic [4:0]  rs1,
	input  logic [31:0] imm,
	input  logic [31:0] rs1_data,
	input  logic [31:0] rs2_data,
	input  logic [31:0] alu_result,
	input  logic        branch_taken,
	output logic        alu_use_imm,
	output logic        rf_wr,
	output logic [31:0] rf_wr_data,
	output logic        csr_wr,
	output logic [31:0] csr_wr_data,
	input  logic [31:0] csr_rd_data,
	input  logic        csr_addr_allowed,
	output logic        trap_enter,
	output exc_cause_e  trap_cause,
	output logic [31:0] trap_pc,
	output logic [31:0] trap_value,
	output logic        trap_leave,
	input  logic [31:0] trap_vector,
	input  logic [31:0] return_addr,
	input  logic        supervisor_mode,
	output ctrl_state_e state
);
	logic [31:0] pc;
	logic        pc_changed;
	logic        trap_pending;
	logic        fetching;
	logic        misaligned;
	logic        csr_insn;
	logic        is_ecall;
	logic        is_sret;
	logic        take_jump;
	logic [31:0] jump_target;
	logic [31:0] csr_operand;
	logic [31:0] load_data;

	assign fetching = state == st_fetch_req || state == st_fetch_wait;
	assign ma_addr = fetching ? pc : rs1_data + imm;
	assign ma_data_out = rs2_data;

	always_comb begin
		ma_data_mask = 4'b1111;
		if (!fetching) begin
			case (funct3[1:0])
			2'b00: ma_data_mask = 4'b0001;
			2'b01: ma_data_mask = 4'b0011;
			default: ma_data_mask = 4'b1111;
			endcase
		end
	end

	assign misaligned = (ma_data_mask == 4'b0011 && ma_addr[0]) ||
		(ma_data_mask == 4'b1111 && ma_addr[1:0] != 2'b00);

	// funct3 100 is reserved in the system space
	assign csr_insn = opcode == opc_system && funct3 != csr_priv && funct3 != 3'b100;
	assign is_ecall = opcode == opc_system && funct3 == csr_priv && imm[11:0] == 12'h000;
	assign is_sret = opcode == opc_system && funct3 == csr_priv && imm[11:0] == 12'h102 &&
		supervisor_mode;

	assign take_jump = opcode == opc_jal || opcode == opc_jalr || branch_taken || is_sret;

	always_comb begin
		case (opcode)
		opc_jalr: jump_target = (rs1_data + imm) & ~32'h1;
		opc_system: jump_target = return_addr;
		default: jump_target = pc + imm;
		endcase
	end

	// immediate forms take the rs1 field as uimm
	assign csr_operand = funct3[2] ? {27'b0, rs1} : rs1_data;

	always_comb begin
		case (csr_op_e'(funct3))
		csr_rs, csr_rsi: csr_wr_data = csr_rd_data | csr_operand;
		csr_rc, csr_rci: csr_wr_data = csr_rd_data & ~csr_operand;
		default: csr_wr_data = csr_operand;
		endcase
	end

	// set and clear with x0 leave the csr alone
	assign csr_wr = state == st_execute && csr_insn && (funct3[1:0] == 2'b01 || rs1 != 5'd0);

	always_comb begin
		case (load_width_e'(funct3))
		lw_byte: load_data = {{24{ma_data_in[7]}}, ma_data_in[7:0]};
		lw_half: load_data = {{16{ma_data_in[15]}}, ma_data_in[15:0]};
		lw_byte_u: load_data = {24'b0, ma_data_in[7:0]};
		lw_half_u: load_data = {16'b0, ma_data_in[15:0]};
		default: load_data = ma_data_in;
		endcase
	end

	always_comb begin
		case (opcode)
		opc_lui: rf_wr_data = imm;
		opc_auipc: rf_wr_data = pc + imm;
		opc_jal, opc_jalr: rf_wr_data = pc + 32'd4;
		opc_system: rf_wr_data = csr_rd_data;
		opc_load: rf_wr_data = load_data;
		default: rf_wr_data = alu_result;
		endcase
	end

	always_comb begin
		rf_wr = 1'b0;
		if (state == st_execute) begin
			case (opcode)
			opc_lui, opc_auipc, opc_jal, opc_jalr, opc_op_imm, opc_op: rf_wr = 1'b1;
			opc_system: rf_wr = csr_insn && csr_addr_allowed;
			default: rf_wr = 1'b0;
			endcase
		end else if (state == st_mem_wait) begin
			rf_wr = ma_rd_req && ma_done;
		end
		if (rd == 5'd0)
			rf_wr = 1'b0;
	end

	assign alu_use_imm = opcode == opc_op_imm;
	assign ir_load = state == st_fetch_wait && ma_done;
	assign trap_enter = state == st_check_trap && trap_pending;
	assign trap_leave = state == st_execute && is_sret;

	task automatic raise_trap(input exc_cause_e cause, input logic [31:0] value);
		state <= st_check_trap;
		trap_pending <= 1'b1;
		trap_cause <= cause;
		trap_pc <= pc;
		trap_value <= value;
	endtask

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= st_fetch_req;
			pc <= `CPU_EXEC_START_ADDR;
			pc_changed <= 1'b0;
			ma_rd_req <= 1'b0;
			ma_wr_req <= 1'b0;
			trap_pending <= 1'b0;
			trap_cause <= exc_insn_misaligned;
			trap_pc <= 32'b0;
			trap_value <= 32'b0;
		end else begin
			case (state)
			st_fetch_req: begin
				if (misaligned) begin
					raise_trap(exc_insn_misaligned, pc);
				end else begin
					ma_rd_req <= 1'b1;
					state <= st_fetch_wait;
				end
			end
			st_fetch_wait: begin
				if (ma_timeout) begin
					ma_rd_req <= 1'b0;
					raise_trap(exc_insn_fault, pc);
				end else if (ma_done) begin
					ma_rd_req <= 1'b0;
					state <= st_decode;
				end
			end
			st_decode: state <= st_execute;
			st_execute: begin
				if (take_jump) begin
					pc <= jump_target;
					pc_changed <= 1'b1;
				end
				if (opcode == opc_load && misaligned) begin
					raise_trap(exc_load_misaligned, ma_addr);
				end else if (opcode == opc_store && misaligned) begin
					raise_trap(exc_store_misaligned, ma_addr);
				end else if (opcode == opc_load) begin
					ma_rd_req <= 1'b1;
					state <= st_mem_wait;
				end else if (opcode == opc_store) begin
					ma_wr_req <= 1'b1;
					state <= st_mem_wait;
				end else if (is_ecall && supervisor_mode) begin
					raise_trap(exc_super_ecall, 32'b0);
				end else if (is_ecall) begin
					raise_trap(exc_user_ecall, 32'b0);
				end else if (opcode == opc_illegal || (csr_insn && !csr_addr_allowed) ||
					(opcode == opc_system && !csr_insn && !is_ecall && !is_sret)) begin
					raise_trap(exc_illegal, 32'b0);
				end else begin
					state <= st_check_trap;
				end
			end
			st_mem_wait: begin
				if (ma_timeout || ma_done) begin
					ma_rd_req <= 1'b0;
					ma_wr_req <= 1'b0;
				end
				if (ma_timeout && ma_rd_req)
					raise_trap(exc_load_fault, ma_addr);
				else if (ma_timeout)
					raise_trap(exc_store_fault, ma_addr);
				else if (ma_done)
					state <= st_check_trap;
			end
			st_check_trap: begin
				if (trap_pending)
					pc <= trap_vector;
				else if (!pc_changed)
					pc <= pc + 32'd4;
				trap_pending <= 1'b0;
				pc_changed <= 1'b0;
				state <= st_fetch_req;
			end
			default: state <= st_fetch_req;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (rst) !(ma_rd_req && ma_wr_req));

	// address held until the memory answers
	assert property (@(posedge clk) disable iff (rst)
		(ma_rd_req || ma_wr_req) && !ma_done && !ma_timeout |=> $stable(ma_addr));

endmodule

`default_nettype wire

//--- logic/cpu_csrs.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpu_csrs import cpu_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic [11:0] addr,
	output logic        addr_allowed,
	input  logic        wr,
	input  logic [31:0] wr_data,
	output logic [31:0] rd_data,
	input  ctrl_state_e state,
	input  logic        trap_enter,
	input  exc_cause_e  cause,
	input  logic [31:0] trap_pc,
	input  logic [31:0] trap_value,
	input  logic        trap_leave,
	output logic [31:0] trap_vector,
	output logic [31:0] return_addr,
	output logic        supervisor_mode
);
	localparam logic [11:0] addr_sstatus  = 12'h100;
	localparam logic [11:0] addr_stvec    = 12'h105;
	localparam logic [11:0] addr_sscratch = 12'h140;
	localparam logic [11:0] addr_sepc     = 12'h141;
	localparam logic [11:0] addr_scause   = 12'h142;
	localparam logic [11:0] addr_stval    = 12'h143;
	localparam logic [11:0] addr_cycle    = 12'hc00;
	localparam logic [11:0] addr_instret  = 12'hc02;

	logic        spp;
	logic [31:0] stvec;
	logic [31:0] sscratch;
	logic [31:0] sepc;
	logic [31:0] scause;
	logic [31:0] stval;
	logic [31:0] cycle;
	logic [31:0] instret;
	logic        known;
	logic        wr_ok;

	always_comb begin
		known = 1'b1;
		rd_data = 32'b0;
		case (addr)
		addr_sstatus: rd_data = {23'b0, spp, 8'b0};
		addr_stvec: rd_data = stvec;
		addr_sscratch: rd_data = sscratch;
		addr_sepc: rd_data = sepc;
		addr_scause: rd_data = scause;
		addr_stval: rd_data = stval;
		addr_cycle: rd_data = cycle;
		addr_instret: rd_data = instret;
		default: known = 1'b0;
		endcase
	end

	// top two address bits set means read only
	assign addr_allowed = known && !(addr[11:10] == 2'b11 && wr);
	assign wr_ok = wr && addr_allowed;

	assign trap_vector = stvec;
	assign return_addr = sepc;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			supervisor_mode <= 1'b1;
			spp <= 1'b0;
			stvec <= `CPU_TRAP_VECTOR_RST;
			cycle <= 32'b0;
			instret <= 32'b0;
		end else begin
			cycle <= cycle + 32'd1;
			if (state == st_check_trap && !trap_enter)
				instret <= instret + 32'd1;
			if (trap_enter) begin
				spp <= supervisor_mode;
				supervisor_mode <= 1'b1;
			end else if (trap_leave) begin
				supervisor_mode <= spp;
				spp <= 1'b0;
			end else if (wr_ok && addr == addr_sstatus) begin
				spp <= wr_data[8];
			end
			// direct mode only
			if (wr_ok && addr == addr_stvec)
				stvec <= {wr_data[31:2], 2'b00};
		end
	end

	always_ff @(posedge clk) begin
		if (trap_enter) begin
			sepc <= trap_pc;
			scause <= cause;
			stval <= trap_value;
		end else if (wr_ok) begin
			case (addr)
			addr_sscratch: sscratch <= wr_data;
			addr_sepc: sepc <= {wr_data[31:2], 2'b00};
			addr_scause: scause <= wr_data;
			addr_stval: stval <= wr_data;
			default: ;
			endcase
		end
	end

	// entry is only in check_trap and return only in execute
	assert property (@(posedge clk) disable iff (rst) !(trap_enter && trap_leave));

endmodule

`default_nettype wire

//--- logic/cpu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_alu import cpu_pkg::*; (
	input  opcode_e     opcode,
	input  logic [2:0]  funct3,
	input  logic        funct7_bit5,
	input  logic        use_imm,
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  logic [31:0] imm,
	output logic [31:0] result,
	output logic        branch_taken
);
	logic [31:0] operand;
	logic [4:0]  shamt;
	logic [31:0] sra_result;
	logic        cond;

	assign operand = use_imm ? imm : b;
	assign shamt = operand[4:0];
	assign sra_result = $signed(a) >>> shamt;

	always_comb begin
		case (funct3)
		// sub only exists in the register form
		3'b000: result = (opcode == opc_op && funct7_bit5) ? a - operand : a + operand;
		3'b001: result = a << shamt;
		3'b010: result = {31'b0, $signed(a) < $signed(operand)};
		3'b011: result = {31'b0, a < operand};
		3'b100: result = a ^ operand;
		3'b101: result = funct7_bit5 ? sra_result : a >> shamt;
		3'b110: result = a | operand;
		default: result = a & operand;
		endcase
	end

	// branch compare always on the two registers
	always_comb begin
		case (funct3)
		3'b000: cond = a == b;
		3'b001: cond = a != b;
		3'b100: cond = $signed(a) < $signed(b);
		3'b101: cond = $signed(a) >= $signed(b);
		3'b110: cond = a < b;
		3'b111: cond = a >= b;
		default: cond = 1'b0;
		endcase
	end

	assign branch_taken = opcode == opc_branch && cond;

endmodule

`default_nettype wire

//--- logic/cpu_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpu_reg_file (
	input  logic        clk,
	input  logic [4:0]  rs1,
	input  logic [4:0]  rs2,
	input  logic [4:0]  rd,
	input  logic        wr,
	input  logic [31:0] wr_data,
	output logic [31:0] rs1_data,
	output logic [31:0] rs2_data
);
	logic [31:0] regs [`CPU_NUM_REGS];

	// x0 and indices past the top are never stored
	always_ff @(posedge clk) begin
		if (wr && rd != 5'd0 && rd < `CPU_NUM_REGS)
			regs[rd] <= wr_data;
	end

	assign rs1_data = (rs1 != 5'd0 && rs1 < `CPU_NUM_REGS) ? regs[rs1] : 32'b0;
	assign rs2_data = (rs2 != 5'd0 && rs2 < `CPU_NUM_REGS) ? regs[rs2] : 32'b0;

endmodule

`default_nettype wire

//--- logic/cpu_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_decoder import cpu_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        load,
	input  logic [31:0] instr,
	output opcode_e     opcode,
	output logic [2:0]  funct3,
	output logic        funct7_bit5,
	output logic [4:0]  rd,
	output logic [4:0]  rs1,
	output logic [4:0]  rs2,
	output logic [31:0] imm,
	output logic [11:0] csr_addr
);
	logic [31:0] ir;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			ir <= 32'b0;
		else if (load)
			ir <= instr;
	end

	assign funct3 = ir[14:12];
	assign funct7_bit5 = ir[30];
	assign rd = ir[11:7];
	assign rs1 = ir[19:15];
	assign rs2 = ir[24:20];
	assign csr_addr = ir[31:20];

	always_comb begin
		case (ir[6:0])
		7'b0110111: opcode = opc_lui;
		7'b0010111: opcode = opc_auipc;
		7'b1101111: opcode = opc_jal;
		7'b1100111: opcode = opc_jalr;
		7'b1100011: opcode = opc_branch;
		7'b0000011: opcode = opc_load;
		7'b0100011: opcode = opc_store;
		7'b0010011: opcode = opc_op_imm;
		7'b0110011: opcode = opc_op;
		7'b0001111: opcode = opc_misc_mem;
		7'b1110011: opcode = opc_system;
		default: opcode = opc_illegal;
		endcase
	end

	// I format unless the class says otherwise
	always_comb begin
		case (opcode)
		opc_store: imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
		opc_branch: imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
		opc_lui, opc_auipc: imm = {ir[31:12], 12'b0};
		opc_jal: imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
		default: imm = {{20{ir[31]}}, ir[31:20]};
		endcase
	end

endmodule

`default_nettype wire

//--- logic/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	typedef enum logic [3:0] {
		opc_lui,
		opc_auipc,
		opc_jal,
		opc_jalr,
		opc_branch,
		opc_load,
		opc_store,
		opc_op_imm,
		opc_op,
		opc_misc_mem,
		opc_system,
		opc_illegal
	} opcode_e;

	typedef enum logic [2:0] {
		st_fetch_req,
		st_fetch_wait,
		st_decode,
		st_execute,
		st_mem_wait,
		st_check_trap
	} ctrl_state_e;

	// scause codes, interrupt bit always clear
	typedef enum logic [31:0] {
		exc_insn_misaligned  = 32'd0,
		exc_insn_fault       = 32'd1,
		exc_illegal          = 32'd2,
		exc_load_misaligned  = 32'd4,
		exc_load_fault       = 32'd5,
		exc_store_misaligned = 32'd6,
		exc_store_fault      = 32'd7,
		exc_user_ecall       = 32'd8,
		exc_super_ecall      = 32'd9
	} exc_cause_e;

	typedef enum logic [2:0] {
		lw_byte   = 3'd0,
		lw_half   = 3'd1,
		lw_word   = 3'd2,
		lw_byte_u = 3'd4,
		lw_half_u = 3'd5
	} load_width_e;

	typedef enum logic [2:0] {
		csr_priv = 3'd0,
		csr_rw   = 3'd1,
		csr_rs   = 3'd2,
		csr_rc   = 3'd3,
		csr_rwi  = 3'd5,
		csr_rsi  = 3'd6,
		csr_rci  = 3'd7
	} csr_op_e;

endpackage

`default_nettype wire

//--- include/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// first fetch after reset
`define CPU_EXEC_START_ADDR 32'h4000_0000

// 32 for full RV32I, 16 for the reduced register set
`define CPU_NUM_REGS 32

// stvec after reset
`define CPU_TRAP_VECTOR_RST 32'h4000_1000

`endif
